// ==== Bender.yml ====
package:
  name: intra4_mode_picker

sources:
  - logic/intra4_pred_pkg.sv
  - logic/rd_cost_pkg.sv
  - logic/search_counter.sv
  - logic/mode_search_ctrl.sv
  - logic/intra4_predictor.sv
  - logic/sse_accumulator.sv
  - logic/best_mode_tracker.sv
  - logic/intra4_mode_picker.sv
  - target: test
    files:
      - tests/intra4_mode_picker_tb.sv

// ==== compile.f ====
logic/intra4_pred_pkg.sv
logic/rd_cost_pkg.sv
logic/search_counter.sv
logic/mode_search_ctrl.sv
logic/intra4_predictor.sv
logic/sse_accumulator.sv
logic/best_mode_tracker.sv
logic/intra4_mode_picker.sv
tests/intra4_mode_picker_tb.sv

// ==== logic/best_mode_tracker.sv ====
/*
 * Scores each mode in its score cycle and keeps the lowest one.
 * A mode replaces the best only on a strictly lower score, so ties keep the
 * earlier mode. Best outputs stay put until the next search updates them.
 */

`timescale 1ns/1ns
`default_nettype none

module best_mode_tracker
    import intra4_pred_pkg::*;
    import rd_cost_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               load_i,
    input  wire lambda_t      lambda_i,
    input  wire               row_valid_i,
    input  wire               score_en_i,
    input  wire intra4_mode_e mode_i,
    input  wire [1:0]         row_i,
    input  wire row_t         pred_row_i,
    input  wire sse_t         sse_i,
    output intra4_mode_e      best_mode_o,
    output score_t            best_score_o,
    output sse_t              best_sse_o,
    output block_t            best_pred_o
);

    lambda_t     lambda_q;
    block_t      cand_q;
    logic [26:0] rate_cost;
    score_t      mode_score;

    // ------------------------------------------------------------
    // Lambda and candidate block of the mode in progress
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (load_i) begin
            lambda_q <= lambda_i;
        end
        if (row_valid_i) begin
            cand_q[row_i] <= pred_row_i;
        end
    end

    // ------------------------------------------------------------
    // RD score: 256 * SSE + lambda * header cost
    // ------------------------------------------------------------
    assign rate_cost  = lambda_q * mode_fixed_cost(mode_i);
    assign mode_score = {4'b0000, sse_i, 8'h00} + {5'b00000, rate_cost};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_mode_o  <= MODE_DC;
            best_score_o <= '0;
            best_sse_o   <= '0;
            best_pred_o  <= '0;
        end else if (load_i) begin
            // First scored mode always wins
            best_score_o <= SCORE_MAX;
        end else if (score_en_i && (mode_score < best_score_o)) begin
            best_mode_o  <= mode_i;
            best_score_o <= mode_score;
            best_sse_o   <= sse_i;
            best_pred_o  <= cand_q;
        end
    end

endmodule : best_mode_tracker

`default_nettype wire

// ==== logic/intra4_mode_picker.sv ====
/*
 * 4x4 intra luma mode picker over DC, TM, VE and HE.
 * Start/done pulse handshake; inputs are captured the cycle after start.
 * Results are valid from done_o until the next accepted start.
 */

`timescale 1ns/1ns
`default_nettype none

module intra4_mode_picker
    import intra4_pred_pkg::*;
    import rd_cost_pkg::*;
#(
    parameter int MODE_COUNT = 4
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               start_i,
    input  wire block_t       src_i,
    input  wire row_t         top_i,
    input  wire pixel_t       top_right_i,
    input  wire row_t         left_i,
    input  wire pixel_t       top_left_i,
    input  wire lambda_t      lambda_i,
    output logic              busy_o,
    output logic              done_o,
    output intra4_mode_e      best_mode_o,
    output score_t            best_score_o,
    output sse_t              best_sse_o,
    output block_t            best_pred_o
);

    // ------------------------------------------------------------
    // Control strobes and counts
    // ------------------------------------------------------------
    logic         load;
    logic         row_valid;
    logic         score_en;
    logic         last_row;
    logic         last_mode;
    intra4_mode_e mode_idx;
    logic [1:0]   row_idx;

    // Datapath
    row_t         pred_row;
    sse_t         mode_sse;

    mode_search_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .last_row_i  (last_row),
        .last_mode_i (last_mode),
        .load_o      (load),
        .row_valid_o (row_valid),
        .score_en_o  (score_en),
        .done_o      (done_o),
        .busy_o      (busy_o)
    );

    search_counter #(
        .MODE_COUNT (MODE_COUNT)
    ) u_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear_i     (load),
        .row_step_i  (row_valid),
        .mode_step_i (score_en),
        .mode_o      (mode_idx),
        .row_o       (row_idx),
        .last_row_o  (last_row),
        .last_mode_o (last_mode)
    );

    intra4_predictor u_pred (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_i      (load),
        .top_i       (top_i),
        .top_right_i (top_right_i),
        .left_i      (left_i),
        .top_left_i  (top_left_i),
        .mode_i      (mode_idx),
        .row_i       (row_idx),
        .pred_row_o  (pred_row)
    );

    sse_accumulator u_sse (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_i      (load),
        .src_i       (src_i),
        .row_valid_i (row_valid),
        .score_en_i  (score_en),
        .row_i       (row_idx),
        .pred_row_i  (pred_row),
        .sse_o       (mode_sse)
    );

    best_mode_tracker u_best (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_i       (load),
        .lambda_i     (lambda_i),
        .row_valid_i  (row_valid),
        .score_en_i   (score_en),
        .mode_i       (mode_idx),
        .row_i        (row_idx),
        .pred_row_i   (pred_row),
        .sse_i        (mode_sse),
        .best_mode_o  (best_mode_o),
        .best_score_o (best_score_o),
        .best_sse_o   (best_sse_o),
        .best_pred_o  (best_pred_o)
    );

endmodule : intra4_mode_picker

`default_nettype wire

// ==== logic/intra4_pred_pkg.sv ====
/*
 * Pixel, row and block containers for the 4x4 luma mode picker.
 * Pixel x of a row sits at bits 8x upward, row y of a block at bits 32y upward.
 * Only the four non-diagonal prediction modes exist here.
 * Enum order is both the search order and the tie-break order.
 */

`default_nettype none

package intra4_pred_pkg;

    // ------------------------------------------------------------
    // Sample containers
    // ------------------------------------------------------------

    // One 8-bit luma sample
    typedef logic [7:0] pixel_t;

    // Element 0 is the leftmost pixel
    typedef pixel_t [3:0] row_t;

    // Element 0 is the top row
    typedef row_t [3:0] block_t;

    // ------------------------------------------------------------
    // Prediction modes
    // ------------------------------------------------------------

    // Lower value wins a tie on score
    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } intra4_mode_e;

endpackage : intra4_pred_pkg

`default_nettype wire

// ==== logic/intra4_predictor.sv ====
/*
 * Predicted row for DC, TM, VE and HE from neighbours latched on load_i.
 * pred_row_o is combinational in mode_i and row_i. DC is computed once at load.
 * VE extends the top row with top-left and top-right; HE repeats left[3] below.
 */

`timescale 1ns/1ns
`default_nettype none

module intra4_predictor
    import intra4_pred_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          load_i,
    input  wire row_t    top_i,
    input  wire pixel_t  top_right_i,
    input  wire row_t    left_i,
    input  wire pixel_t  top_left_i,
    input  wire intra4_mode_e mode_i,
    input  wire [1:0]    row_i,
    output row_t         pred_row_o
);

    row_t          top_q;
    row_t          left_q;
    pixel_t        top_right_q;
    pixel_t        top_left_q;
    pixel_t        dc_q;
    logic [10:0]   dc_sum;
    pixel_t [5:0]  top_ext;
    pixel_t [5:0]  left_ext;
    logic [2:0]    ry;
    pixel_t        he_val;

    // Three-tap smoothing with rounding
    function automatic pixel_t avg3(input pixel_t a, input pixel_t b, input pixel_t c);
        logic [9:0] s;
        s = {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c} + 10'd2;
        return s[9:2];
    endfunction

    // left + top - top_left, saturated to a pixel
    function automatic pixel_t tm_clip(input pixel_t l, input pixel_t t, input pixel_t tl);
        logic signed [9:0] s;
        pixel_t            r;
        s = $signed({2'b00, l}) + $signed({2'b00, t}) - $signed({2'b00, tl});
        if (s < 0)
            r = 8'd0;
        else if (s > 10'sd255)
            r = 8'd255;
        else
            r = s[7:0];
        return r;
    endfunction

    always_comb begin
        dc_sum = 11'd4;
        for (int i = 0; i < 4; i++) begin
            dc_sum = dc_sum + top_i[i] + left_i[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            top_q       <= '0;
            left_q      <= '0;
            top_right_q <= '0;
            top_left_q  <= '0;
            dc_q        <= '0;
        end else if (load_i) begin
            top_q       <= top_i;
            left_q      <= left_i;
            top_right_q <= top_right_i;
            top_left_q  <= top_left_i;
            dc_q        <= dc_sum[10:3];
        end
    end

    // Edge rows with the corner and the end pixel attached
    assign top_ext  = {top_right_q, top_q, top_left_q};
    assign left_ext = {left_q[3], left_q, top_left_q};

    assign ry     = {1'b0, row_i};
    assign he_val = avg3(left_ext[ry], left_ext[ry + 3'd1], left_ext[ry + 3'd2]);

    always_comb begin
        for (int x = 0; x < 4; x++) begin
            case (mode_i)
                MODE_DC: pred_row_o[x] = dc_q;
                MODE_TM: pred_row_o[x] = tm_clip(left_q[row_i], top_q[x], top_left_q);
                MODE_VE: pred_row_o[x] = avg3(top_ext[x], top_ext[x + 1], top_ext[x + 2]);
                default: pred_row_o[x] = he_val;
            endcase
        end
    end

endmodule : intra4_predictor

`default_nettype wire

// ==== logic/mode_search_ctrl.sv ====
/*
 * Sequencer for one block: load, four rows per mode, a score cycle per mode, done.
 * start_i is only looked at in IDLE. Every output is registered.
 */

`timescale 1ns/1ns
`default_nettype none

module mode_search_ctrl (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  start_i,
    input  wire  last_row_i,
    input  wire  last_mode_i,
    output logic load_o,
    output logic row_valid_o,
    output logic score_en_o,
    output logic done_o,
    output logic busy_o
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        ROWS,
        SCORE,
        DONE
    } state_e;

    state_e state_q;
    state_e state_d;

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_i) state_d = LOAD;
            LOAD:    state_d = ROWS;
            ROWS:    if (last_row_i) state_d = SCORE;
            SCORE:   state_d = last_mode_i ? DONE : ROWS;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // State and decoded strobes
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            load_o      <= 1'b0;
            row_valid_o <= 1'b0;
            score_en_o  <= 1'b0;
            done_o      <= 1'b0;
            busy_o      <= 1'b0;
        end else begin
            state_q     <= state_d;
            load_o      <= (state_d == LOAD);
            row_valid_o <= (state_d == ROWS);
            score_en_o  <= (state_d == SCORE);
            done_o      <= (state_d == DONE);
            busy_o      <= (state_d != IDLE);
        end
    end

endmodule : mode_search_ctrl

`default_nettype wire

// ==== logic/rd_cost_pkg.sv ====
/*
 * Rate-distortion types and the fixed header cost of each 4x4 mode.
 * Score is 256 * SSE + lambda * header cost and always fits in 29 bits.
 */

`default_nettype none

package rd_cost_pkg;

    import intra4_pred_pkg::*;

    // Max 16 * 255^2 = 1040400, fits in 20 bits
    typedef logic [19:0] sse_t;
    typedef logic [15:0] lambda_t;
    typedef logic [31:0] score_t;
    typedef logic [10:0] hdr_cost_t;

    // Starting point of every best-score search
    localparam score_t SCORE_MAX = '1;

    // ------------------------------------------------------------
    // Header bits of each mode, in 1/256 bit units
    // ------------------------------------------------------------
    function automatic hdr_cost_t mode_fixed_cost(input intra4_mode_e mode);
        hdr_cost_t cost;
        case (mode)
            MODE_DC: cost = 11'd40;
            MODE_TM: cost = 11'd1151;
            MODE_VE: cost = 11'd1723;
            default: cost = 11'd1874;
        endcase
        return cost;
    endfunction

endpackage : rd_cost_pkg

`default_nettype wire

// ==== logic/search_counter.sv ====
/*
 * Row and mode counter for the mode search.
 * MODE_COUNT must be 1 to 4; the first MODE_COUNT modes in enum order are walked.
 */

`timescale 1ns/1ns
`default_nettype none

module search_counter
    import intra4_pred_pkg::*;
#(
    parameter int MODE_COUNT = 4
) (
    input  wire          clk,
    input  wire          rst_n,
    input  wire          clear_i,
    input  wire          row_step_i,
    input  wire          mode_step_i,
    output intra4_mode_e mode_o,
    output logic [1:0]   row_o,
    output logic         last_row_o,
    output logic         last_mode_o
);

    localparam intra4_mode_e LAST_MODE = intra4_mode_e'(MODE_COUNT - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_o  <= 2'd0;
            mode_o <= MODE_DC;
        end else if (clear_i) begin
            row_o  <= 2'd0;
            mode_o <= MODE_DC;
        end else begin
            // Wraps from 3 back to 0 on its own
            if (row_step_i) begin
                row_o <= row_o + 2'd1;
            end
            if (mode_step_i) begin
                mode_o <= intra4_mode_e'(mode_o + 2'd1);
            end
        end
    end

    assign last_row_o  = (row_o == 2'd3);
    assign last_mode_o = (mode_o == LAST_MODE);

endmodule : search_counter

`default_nettype wire

// ==== logic/sse_accumulator.sv ====
/*
 * Per-mode sum of squared errors, one row per row_valid_i.
 * sse_o holds the full mode sum in the score cycle and is cleared after it.
 */

`timescale 1ns/1ns
`default_nettype none

module sse_accumulator
    import intra4_pred_pkg::*;
    import rd_cost_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         load_i,
    input  wire block_t src_i,
    input  wire         row_valid_i,
    input  wire         score_en_i,
    input  wire [1:0]   row_i,
    input  wire row_t   pred_row_i,
    output sse_t        sse_o
);

    block_t      src_q;
    row_t        src_row;
    pixel_t      diff;
    logic [15:0] sq;
    logic [17:0] row_sse;

    always_ff @(posedge clk) begin
        if (load_i) begin
            src_q <= src_i;
        end
    end

    assign src_row = src_q[row_i];

    // Four squared differences of the current row
    always_comb begin
        row_sse = '0;
        for (int x = 0; x < 4; x++) begin
            diff    = (src_row[x] > pred_row_i[x]) ? src_row[x] - pred_row_i[x]
                                                   : pred_row_i[x] - src_row[x];
            sq      = diff * diff;
            row_sse = row_sse + sq;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sse_o <= '0;
        else if (load_i || score_en_i)
            sse_o <= '0;
        else if (row_valid_i)
            sse_o <= sse_o + row_sse;
    end

endmodule : sse_accumulator

`default_nettype wire

// ==== tests/intra4_mode_picker_tb.sv ====
/*
 * Testbench for the 4x4 intra mode picker with all four modes searched.
 * Expected results come from a model of the prediction, SSE and RD rules.
 * Data inputs are held from start until the load cycle has passed.
 */

`timescale 1ns/1ns
`default_nettype none

module intra4_mode_picker_tb
    import intra4_pred_pkg::*;
    import rd_cost_pkg::*;
;

    localparam int MODE_COUNT = 4;
    localparam int TIMEOUT    = 100;

    typedef struct packed {
        intra4_mode_e mode;
        score_t       score;
        sse_t         sse;
        block_t       pred;
    } expect_t;

    logic         clk;
    logic         rst_n;
    logic         start_i;
    block_t       src_i;
    row_t         top_i;
    pixel_t       top_right_i;
    row_t         left_i;
    pixel_t       top_left_i;
    lambda_t      lambda_i;
    logic         busy_o;
    logic         done_o;
    intra4_mode_e best_mode_o;
    score_t       best_score_o;
    sse_t         best_sse_o;
    block_t       best_pred_o;

    expect_t      exp_q[$];
    expect_t      cur_exp;
    logic [31:0]  lfsr_state = 32'h1f01215f;
    int           errors = 0;
    int           checks = 0;
    int           tests  = 0;

    intra4_mode_picker #(
        .MODE_COUNT (MODE_COUNT)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .src_i        (src_i),
        .top_i        (top_i),
        .top_right_i  (top_right_i),
        .left_i       (left_i),
        .top_left_i   (top_left_i),
        .lambda_i     (lambda_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .best_mode_o  (best_mode_o),
        .best_score_o (best_score_o),
        .best_sse_o   (best_sse_o),
        .best_pred_o  (best_pred_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Random source and reference model
    // ------------------------------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int header_cost(input int m);
        int c;
        case (m)
            0:       c = 40;
            1:       c = 1151;
            2:       c = 1723;
            default: c = 1874;
        endcase
        return c;
    endfunction

    function automatic int pred_pixel(input int m, input row_t top, input pixel_t tr,
                                      input row_t left, input pixel_t tl,
                                      input int x, input int y);
        int te[6];
        int le[6];
        int s;
        te[0] = int'(tl);
        le[0] = int'(tl);
        for (int i = 0; i < 4; i++) begin
            te[i + 1] = int'(top[i]);
            le[i + 1] = int'(left[i]);
        end
        te[5] = int'(tr);
        le[5] = int'(left[3]);
        case (m)
            0: begin
                s = 4;
                for (int i = 0; i < 4; i++)
                    s = s + te[i + 1] + le[i + 1];
                s = s >> 3;
            end
            1: begin
                s = le[y + 1] + te[x + 1] - int'(tl);
                if (s < 0)
                    s = 0;
                if (s > 255)
                    s = 255;
            end
            2:       s = (te[x] + 2 * te[x + 1] + te[x + 2] + 2) >> 2;
            default: s = (le[y] + 2 * le[y + 1] + le[y + 2] + 2) >> 2;
        endcase
        return s;
    endfunction

    function automatic expect_t ref_pick(input block_t src, input row_t top, input pixel_t tr,
                                         input row_t left, input pixel_t tl, input lambda_t lam);
        expect_t best;
        block_t  pred;
        longint  best_score;
        longint  score;
        int      sse;
        int      d;
        best       = '0;
        best_score = 64'd1 << 40;
        for (int m = 0; m < MODE_COUNT; m++) begin
            sse = 0;
            for (int y = 0; y < 4; y++) begin
                for (int x = 0; x < 4; x++) begin
                    pred[y][x] = pixel_t'(pred_pixel(m, top, tr, left, tl, x, y));
                    d = int'(src[y][x]) - int'(pred[y][x]);
                    sse = sse + d * d;
                end
            end
            score = 256 * longint'(sse) + longint'(lam) * header_cost(m);
            // Strictly lower only, so ties keep the earlier mode
            if (score < best_score) begin
                best_score = score;
                best.mode  = intra4_mode_e'(m);
                best.score = score_t'(score);
                best.sse   = sse_t'(sse);
                best.pred  = pred;
            end
        end
        return best;
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_mode(input string name, input intra4_mode_e got,
                              input intra4_mode_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_score(input string name, input score_t got, input score_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_sse(input string name, input sse_t got, input sse_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_block(input string name, input block_t got, input block_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED done_o latency: got 0x%0h expected 0x%0h", got, exp);
        end
    endtask

    // Results checked on every done pulse
    always @(negedge clk) begin
        if (rst_n && done_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("done_o pulsed while no block was outstanding");
            end else begin
                cur_exp = exp_q.pop_front();
                check_mode("best_mode_o", best_mode_o, cur_exp.mode);
                check_score("best_score_o", best_score_o, cur_exp.score);
                check_sse("best_sse_o", best_sse_o, cur_exp.sse);
                check_block("best_pred_o", best_pred_o, cur_exp.pred);
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic random_block(output block_t s, output row_t t, output pixel_t tr,
                                output row_t l, output pixel_t tl, output lambda_t lam);
        logic [31:0] v;
        for (int y = 0; y < 4; y++) begin
            random_bits(32, v);
            s[y] = v;
        end
        random_bits(32, v);
        t = v;
        random_bits(32, v);
        l = v;
        random_bits(8, v);
        tr = v[7:0];
        random_bits(8, v);
        tl = v[7:0];
        random_bits(16, v);
        lam = v[15:0];
    endtask

    // With disturb set, start pulses while busy and inputs change after capture
    task automatic run_block(input block_t s, input row_t t, input pixel_t tr,
                             input row_t l, input pixel_t tl, input lambda_t lam,
                             input bit disturb, output int cycles, output bit busy_ok);
        int k;
        bit seen;
        exp_q.push_back(ref_pick(s, t, tr, l, tl, lam));
        @(posedge clk);
        start_i     <= 1'b1;
        src_i       <= s;
        top_i       <= t;
        top_right_i <= tr;
        left_i      <= l;
        top_left_i  <= tl;
        lambda_i    <= lam;
        k       = 0;
        seen    = 0;
        cycles  = 0;
        busy_ok = 1;
        while (!seen && k < TIMEOUT) begin
            @(posedge clk);
            start_i <= disturb && (k >= 4) && (k <= 6);
            if (disturb && k >= 1) begin
                src_i       <= ~s;
                top_i       <= ~t;
                top_right_i <= ~tr;
                left_i      <= ~l;
                top_left_i  <= ~tl;
                lambda_i    <= ~lam;
            end
            @(negedge clk);
            k++;
            if (!busy_o)
                busy_ok = 0;
            if (done_o) begin
                seen   = 1;
                cycles = k;
            end
        end
        if (!seen) begin
            errors++;
            exp_q.delete();
            $display("Timeout: done_o did not rise within %0d cycles of start", TIMEOUT);
        end
        @(posedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before)
            $display("%-12s ok", name);
        else
            $display("%-12s %0d errors", name, errors - errs_before);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        block_t  s;
        row_t    t;
        row_t    l;
        pixel_t  tr;
        pixel_t  tl;
        lambda_t lam;
        int      cycles;
        bit      busy_ok;
        int      e0;

        rst_n       = 1'b0;
        start_i     = 1'b0;
        src_i       = '0;
        top_i       = '0;
        top_right_i = '0;
        left_i      = '0;
        top_left_i  = '0;
        lambda_i    = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state
        e0 = errors;
        @(negedge clk);
        check_bit("done_o", done_o, 1'b0);
        check_bit("busy_o", busy_o, 1'b0);
        check_mode("best_mode_o", best_mode_o, MODE_DC);
        check_score("best_score_o", best_score_o, '0);
        check_sse("best_sse_o", best_sse_o, '0);
        check_block("best_pred_o", best_pred_o, '0);
        report_test("reset", e0);

        // Flat block, every mode exact
        e0  = errors;
        t   = {4{8'h6e}};
        s   = {16{8'h6e}};
        lam = 16'd300;
        run_block(s, t, 8'h6e, t, 8'h6e, lam, 1'b0, cycles, busy_ok);
        check_mode("best_mode_o", best_mode_o, MODE_DC);
        check_score("best_score_o", best_score_o, score_t'(lam) * 40);
        check_sse("best_sse_o", best_sse_o, '0);
        check_block("best_pred_o", best_pred_o, s);
        report_test("flat", e0);

        // Equal scores with zero lambda, then HE-shaped source with heavy lambda
        e0 = errors;
        random_block(s, t, tr, l, tl, lam);
        t = {4{8'h40}};
        run_block(s, t, 8'h40, t, 8'h40, 16'd0, 1'b0, cycles, busy_ok);
        check_mode("best_mode_o", best_mode_o, MODE_DC);
        t  = {4{8'h80}};
        l  = {8'hd0, 8'h90, 8'h50, 8'h10};
        tl = 8'h80;
        tr = 8'h80;
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++)
                s[y][x] = pixel_t'(pred_pixel(3, t, tr, l, tl, x, y));
        end
        run_block(s, t, tr, l, tl, 16'hffff, 1'b0, cycles, busy_ok);
        report_test("tie-break", e0);

        e0 = errors;
        for (int n = 0; n < 40; n++) begin
            random_block(s, t, tr, l, tl, lam);
            run_block(s, t, tr, l, tl, lam, 1'b0, cycles, busy_ok);
        end
        report_test("random", e0);

        // Latency with ignored start pulses and inputs changed after capture
        e0 = errors;
        random_block(s, t, tr, l, tl, lam);
        run_block(s, t, tr, l, tl, lam, 1'b1, cycles, busy_ok);
        check_latency(cycles, 5 * MODE_COUNT + 2);
        check_bit("busy_o", busy_ok, 1'b1);
        report_test("timing", e0);

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule : intra4_mode_picker_tb

`default_nettype wire
